// ==== fm_eg_top.f ====
+incdir+include
logic/fm_eg_reg_pkg.sv
logic/fm_eg_env_pkg.sv
logic/fm_eg_apb_regs.sv
logic/fm_eg_timer.sv
logic/fm_eg_rate.sv
logic/fm_eg_phase.sv
logic/fm_eg_attenuation.sv
logic/fm_eg_top.sv
testbench/fm_eg_tb.sv

// ==== include/fm_eg_params.svh ====
`ifndef FM_EG_PARAMS_SVH
`define FM_EG_PARAMS_SVH

// slot multiplex.
`define EG_SLOTS 4
`define EG_SLOT_W 2

// attenuation level where 0 is loudest.
`define EG_LEVEL_W 10
`define EG_LEVEL_MAX 10'h3FF

// global envelope counter and its round divider.
`define EG_CNT_W 12
`define EG_ROUND_DIV 3

// register bus.
`define APB_ADDR_W 5
`define APB_DATA_W 8

`endif

// ==== logic/fm_eg_apb_regs.sv ====
`timescale 1ns/1ps

`include "fm_eg_params.svh"

module fm_eg_apb_regs
	(
	input logic mclk_i,
	input logic rst_n_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [`APB_ADDR_W-1:0] paddr_i,
	input logic [`APB_DATA_W-1:0] pwdata_i,
	output logic [`APB_DATA_W-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input fm_eg_env_pkg::slot_t slot_i,
	output fm_eg_reg_pkg::rate_t ar_o,
	output fm_eg_reg_pkg::rate_t dr_o,
	output fm_eg_reg_pkg::rate_t sr_o,
	output fm_eg_reg_pkg::rr_t rr_o,
	output fm_eg_reg_pkg::sl_t sl_o,
	output fm_eg_reg_pkg::tl_t tl_o,
	output fm_eg_reg_pkg::ks_t ks_o,
	output fm_eg_reg_pkg::kcode_t kcode_o,
	output logic key_o
	);

	import fm_eg_reg_pkg::*;
	import fm_eg_env_pkg::*;

	rate_t ar_q [`EG_SLOTS];
	rate_t dr_q [`EG_SLOTS];
	rate_t sr_q [`EG_SLOTS];
	rr_t rr_q [`EG_SLOTS];
	sl_t sl_q [`EG_SLOTS];
	tl_t tl_q [`EG_SLOTS];
	ks_t ks_q [`EG_SLOTS];
	kcode_t kcode_q [`EG_SLOTS];
	logic key_q [`EG_SLOTS];

	logic access;
	logic bad_idx;
	slot_t bus_slot;
	reg_idx_e bus_idx;

	assign access = psel_i & penable_i;
	assign bus_slot = paddr_i[4:3];
	assign bus_idx = reg_idx_e'(paddr_i[2:0]);
	assign bad_idx = (paddr_i[2:0] == 3'd7);

	assign pready_o = access; // no wait states.
	assign pslverr_o = access & bad_idx;

	always_ff @(posedge mclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < `EG_SLOTS; i++)
			begin
				ar_q[i] <= '0;
				dr_q[i] <= '0;
				sr_q[i] <= '0;
				rr_q[i] <= '0;
				sl_q[i] <= '0;
				tl_q[i] <= '0;
				ks_q[i] <= '0;
				kcode_q[i] <= '0;
				key_q[i] <= 1'b0;
			end
		end
		else if (access & pwrite_i)
		begin
			case (bus_idx)
				REG_AR: ar_q[bus_slot] <= pwdata_i[4:0];
				REG_DR: dr_q[bus_slot] <= pwdata_i[4:0];
				REG_SR: sr_q[bus_slot] <= pwdata_i[4:0];
				REG_RR_SL:
				begin
					rr_q[bus_slot] <= pwdata_i[3:0];
					sl_q[bus_slot] <= pwdata_i[7:4];
				end
				REG_TL: tl_q[bus_slot] <= pwdata_i[6:0];
				REG_KS_KC:
				begin
					kcode_q[bus_slot] <= pwdata_i[4:0];
					ks_q[bus_slot] <= pwdata_i[6:5];
				end
				REG_KEY: key_q[bus_slot] <= pwdata_i[0];
				default: ; // index 7 writes nothing.
			endcase
		end
	end

	always_comb
	begin
		prdata_o = '0;
		case (bus_idx)
			REG_AR: prdata_o = {3'b000, ar_q[bus_slot]};
			REG_DR: prdata_o = {3'b000, dr_q[bus_slot]};
			REG_SR: prdata_o = {3'b000, sr_q[bus_slot]};
			REG_RR_SL: prdata_o = {sl_q[bus_slot], rr_q[bus_slot]};
			REG_TL: prdata_o = {1'b0, tl_q[bus_slot]};
			REG_KS_KC: prdata_o = {1'b0, ks_q[bus_slot], kcode_q[bus_slot]};
			REG_KEY: prdata_o = {7'b0000000, key_q[bus_slot]};
			default: prdata_o = '0;
		endcase
	end

	// settings of the slot being served.
	assign ar_o = ar_q[slot_i];
	assign dr_o = dr_q[slot_i];
	assign sr_o = sr_q[slot_i];
	assign rr_o = rr_q[slot_i];
	assign sl_o = sl_q[slot_i];
	assign tl_o = tl_q[slot_i];
	assign ks_o = ks_q[slot_i];
	assign kcode_o = kcode_q[slot_i];
	assign key_o = key_q[slot_i];

endmodule

// ==== logic/fm_eg_attenuation.sv ====
`timescale 1ns/1ps

`include "fm_eg_params.svh"

module fm_eg_attenuation
	(
	input logic mclk_i,
	input logic rst_n_i,
	input fm_eg_env_pkg::slot_t slot_i,
	input fm_eg_env_pkg::level_t level_i,
	input fm_eg_reg_pkg::tl_t tl_i,
	output fm_eg_env_pkg::level_t eg_level_o,
	output fm_eg_env_pkg::slot_t eg_slot_o
	);

	import fm_eg_env_pkg::*;

	logic [10:0] tl_sum;
	level_t level_sat;

	assign tl_sum = {1'b0, level_i} + {1'b0, tl_i, 3'b000}; // tl in steps of 8.
	assign level_sat = tl_sum[10] ? `EG_LEVEL_MAX : tl_sum[9:0];

	always_ff @(posedge mclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			eg_level_o <= `EG_LEVEL_MAX;
			eg_slot_o <= '0;
		end
		else
		begin
			eg_level_o <= level_sat;
			eg_slot_o <= slot_i;
		end
	end

endmodule

// ==== logic/fm_eg_env_pkg.sv ====
package fm_eg_env_pkg;

`include "fm_eg_params.svh"

	typedef logic [`EG_LEVEL_W-1:0] level_t;
	typedef logic [5:0] eff_rate_t; // 0 to 63.
	typedef logic [4:0] inc_t;
	typedef logic [`EG_SLOT_W-1:0] slot_t;
	typedef logic [`EG_CNT_W-1:0] eg_cnt_t;

	typedef enum logic [1:0]
	{
		PH_ATTACK = 2'd0,
		PH_DECAY = 2'd1,
		PH_SUSTAIN = 2'd2,
		PH_RELEASE = 2'd3
	} eg_phase_e;

endpackage

// ==== logic/fm_eg_phase.sv ====
`timescale 1ns/1ps

`include "fm_eg_params.svh"

module fm_eg_phase
	(
	input logic mclk_i,
	input logic rst_n_i,
	input fm_eg_env_pkg::slot_t slot_i,
	input logic tick_i,
	input logic key_i,
	input fm_eg_reg_pkg::sl_t sl_i,
	input logic step_i,
	input fm_eg_env_pkg::inc_t inc_i,
	input logic instant_i,
	output fm_eg_env_pkg::eg_phase_e phase_o,
	output fm_eg_env_pkg::level_t level_o
	);

	import fm_eg_env_pkg::*;

	eg_phase_e phase_q [`EG_SLOTS];
	level_t level_q [`EG_SLOTS];
	logic key_q [`EG_SLOTS];

	eg_phase_e phase_cur;
	eg_phase_e phase_edge;
	eg_phase_e phase_nxt;
	level_t level_cur;
	level_t level_nxt;
	logic key_rise;
	logic key_fall;
	logic [10:0] att_dec;
	logic [10:0] lin_sum;

	assign phase_cur = phase_q[slot_i];
	assign level_cur = level_q[slot_i];
	assign key_rise = key_i & ~key_q[slot_i];
	assign key_fall = ~key_i & key_q[slot_i];

	// key edges pick the phase that the rate block sees.
	assign phase_edge = key_rise ? PH_ATTACK : (key_fall ? PH_RELEASE : phase_cur);
	assign phase_o = phase_edge;

	assign att_dec = ({5'b00000, level_cur[9:4]} + 11'd1) * inc_i; // exponential attack.
	assign lin_sum = {1'b0, level_cur} + inc_i;

	always_comb
	begin
		level_nxt = level_cur;
		if (key_rise)
		begin
			if (instant_i)
				level_nxt = '0;
		end
		else if (!key_fall && step_i)
		begin
			if (phase_cur == PH_ATTACK)
				level_nxt = (att_dec >= {1'b0, level_cur}) ? '0 : level_cur - att_dec[9:0];
			else
				level_nxt = lin_sum[10] ? `EG_LEVEL_MAX : lin_sum[9:0];
		end

		phase_nxt = phase_edge;
		case (phase_edge)
			PH_ATTACK:
				if (level_nxt == '0)
					phase_nxt = PH_DECAY;
			PH_DECAY:
				if (level_nxt >= {1'b0, sl_i, 5'b00000})
					phase_nxt = PH_SUSTAIN;
			default: ;
		endcase
	end

	always_ff @(posedge mclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < `EG_SLOTS; i++)
			begin
				phase_q[i] <= PH_RELEASE;
				level_q[i] <= `EG_LEVEL_MAX;
				key_q[i] <= 1'b0;
			end
		end
		else if (tick_i)
		begin
			phase_q[slot_i] <= phase_nxt;
			level_q[slot_i] <= level_nxt;
			key_q[slot_i] <= key_i;
		end
	end

	assign level_o = tick_i ? level_nxt : level_cur;

endmodule

// ==== logic/fm_eg_rate.sv ====
`timescale 1ns/1ps

module fm_eg_rate
	(
	input fm_eg_env_pkg::eg_phase_e phase_i,
	input fm_eg_reg_pkg::rate_t ar_i,
	input fm_eg_reg_pkg::rate_t dr_i,
	input fm_eg_reg_pkg::rate_t sr_i,
	input fm_eg_reg_pkg::rr_t rr_i,
	input fm_eg_reg_pkg::ks_t ks_i,
	input fm_eg_reg_pkg::kcode_t kcode_i,
	input fm_eg_env_pkg::eg_cnt_t eg_cnt_i,
	output logic step_o,
	output fm_eg_env_pkg::inc_t inc_o,
	output logic instant_o
	);

	import fm_eg_reg_pkg::*;
	import fm_eg_env_pkg::*;

	rate_t base;
	kcode_t ks_add;
	logic [6:0] rate_sum;
	eff_rate_t eff;
	logic fast;
	logic [3:0] shift;
	eg_cnt_t cnt_mask;

	always_comb
	begin
		case (phase_i)
			PH_ATTACK: base = ar_i;
			PH_DECAY: base = dr_i;
			PH_SUSTAIN: base = sr_i;
			default: base = {rr_i, 1'b1}; // release runs at rr*2+1.
		endcase
	end

	assign ks_add = kcode_i >> (2'd3 - ks_i);
	assign rate_sum = {1'b0, base, 1'b0} + {2'b00, ks_add};
	assign eff = (base == '0) ? '0 : (rate_sum[6] ? 6'd63 : rate_sum[5:0]);

	// rates 48 and up step every tick with a larger increment.
	assign fast = (eff[5:4] == 2'b11);
	assign shift = fast ? 4'd0 : 4'd11 - eff[5:2];
	assign cnt_mask = (eg_cnt_t'(1) << shift) - 1'b1;

	assign step_o = (eff != '0) && ((eg_cnt_i & cnt_mask) == '0);
	assign inc_o = fast ? inc_t'(1) << (eff[5:2] - 4'd11) : inc_t'(1);
	assign instant_o = (eff >= 6'd62);

endmodule

// ==== logic/fm_eg_reg_pkg.sv ====
package fm_eg_reg_pkg;

`include "fm_eg_params.svh"

	typedef logic [4:0] rate_t; // ar, dr, sr.
	typedef logic [3:0] rr_t;
	typedef logic [3:0] sl_t;
	typedef logic [6:0] tl_t;
	typedef logic [1:0] ks_t;
	typedef logic [4:0] kcode_t;

	// low address bits below the slot field.
	typedef enum logic [`APB_ADDR_W-`EG_SLOT_W-1:0]
	{
		REG_AR = 3'd0,
		REG_DR = 3'd1,
		REG_SR = 3'd2,
		REG_RR_SL = 3'd3,
		REG_TL = 3'd4,
		REG_KS_KC = 3'd5,
		REG_KEY = 3'd6
	} reg_idx_e;

endpackage

// ==== logic/fm_eg_timer.sv ====
`timescale 1ns/1ps

`include "fm_eg_params.svh"

module fm_eg_timer
	(
	input logic mclk_i,
	input logic rst_n_i,
	output fm_eg_env_pkg::slot_t slot_o,
	output logic tick_o,
	output fm_eg_env_pkg::eg_cnt_t eg_cnt_o
	);

	import fm_eg_env_pkg::*;

	slot_t slot_q;
	logic [1:0] round_q;
	eg_cnt_t cnt_q;

	logic slot_wrap;
	logic round_wrap;

	assign slot_wrap = (slot_q == slot_t'(`EG_SLOTS - 1));
	assign round_wrap = (round_q == 2'(`EG_ROUND_DIV - 1));

	always_ff @(posedge mclk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			slot_q <= '0;
			round_q <= '0;
			cnt_q <= '0;
		end
		else
		begin
			slot_q <= slot_wrap ? '0 : slot_q + 1'b1;
			if (slot_wrap)
			begin
				round_q <= round_wrap ? 2'd0 : round_q + 1'b1;
				if (round_wrap)
					cnt_q <= cnt_q + 1'b1; // wraps at 4096.
			end
		end
	end

	assign slot_o = slot_q;
	assign tick_o = (round_q == 2'd0); // first round after a counter step.
	assign eg_cnt_o = cnt_q;

endmodule

// ==== logic/fm_eg_top.sv ====
`timescale 1ns/1ps

`include "fm_eg_params.svh"

module fm_eg_top
	(
	input logic mclk_i,
	input logic rst_n_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [`APB_ADDR_W-1:0] paddr_i,
	input logic [`APB_DATA_W-1:0] pwdata_i,
	output logic [`APB_DATA_W-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	output fm_eg_env_pkg::level_t eg_level_o,
	output fm_eg_env_pkg::slot_t eg_slot_o
	);

	fm_eg_env_pkg::slot_t slot;
	logic tick;
	fm_eg_env_pkg::eg_cnt_t eg_cnt;
	fm_eg_reg_pkg::rate_t ar;
	fm_eg_reg_pkg::rate_t dr;
	fm_eg_reg_pkg::rate_t sr;
	fm_eg_reg_pkg::rr_t rr;
	fm_eg_reg_pkg::sl_t sl;
	fm_eg_reg_pkg::tl_t tl;
	fm_eg_reg_pkg::ks_t ks;
	fm_eg_reg_pkg::kcode_t kcode;
	logic key;
	fm_eg_env_pkg::eg_phase_e phase;
	logic step;
	fm_eg_env_pkg::inc_t inc;
	logic instant;
	fm_eg_env_pkg::level_t level;

	fm_eg_timer timer_i
		(
		.mclk_i(mclk_i),
		.rst_n_i(rst_n_i),
		.slot_o(slot),
		.tick_o(tick),
		.eg_cnt_o(eg_cnt)
		);

	fm_eg_apb_regs regs_i
		(
		.mclk_i(mclk_i),
		.rst_n_i(rst_n_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.slot_i(slot),
		.ar_o(ar),
		.dr_o(dr),
		.sr_o(sr),
		.rr_o(rr),
		.sl_o(sl),
		.tl_o(tl),
		.ks_o(ks),
		.kcode_o(kcode),
		.key_o(key)
		);

	fm_eg_rate rate_i
		(
		.phase_i(phase),
		.ar_i(ar),
		.dr_i(dr),
		.sr_i(sr),
		.rr_i(rr),
		.ks_i(ks),
		.kcode_i(kcode),
		.eg_cnt_i(eg_cnt),
		.step_o(step),
		.inc_o(inc),
		.instant_o(instant)
		);

	fm_eg_phase phase_i
		(
		.mclk_i(mclk_i),
		.rst_n_i(rst_n_i),
		.slot_i(slot),
		.tick_i(tick),
		.key_i(key),
		.sl_i(sl),
		.step_i(step),
		.inc_i(inc),
		.instant_i(instant),
		.phase_o(phase),
		.level_o(level)
		);

	fm_eg_attenuation atten_i
		(
		.mclk_i(mclk_i),
		.rst_n_i(rst_n_i),
		.slot_i(slot),
		.level_i(level),
		.tl_i(tl),
		.eg_level_o(eg_level_o),
		.eg_slot_o(eg_slot_o)
		);

endmodule

// ==== testbench/fm_eg_tb.sv ====
`timescale 1ns/1ps

`include "fm_eg_params.svh"

module fm_eg_tb;

	localparam int RAND_TXNS = 1500;
	localparam int WAIT_LIMIT = 2000;
	localparam int HOLD_CYCLES = 240;
	localparam int CYCLE_LIMIT = 16 + 8 + 400 + 8 * WAIT_LIMIT + 3 * HOLD_CYCLES
		+ RAND_TXNS * 10 + 500;

	localparam int PH_ATT = 0;
	localparam int PH_DEC = 1;
	localparam int PH_SUS = 2;
	localparam int PH_REL = 3;

	logic mclk = 1'b0;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_W-1:0] paddr;
	logic [`APB_DATA_W-1:0] pwdata;
	logic [`APB_DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [`EG_LEVEL_W-1:0] eg_level;
	logic [`EG_SLOT_W-1:0] eg_slot;

	// reference model state.
	int m_reg [`EG_SLOTS][8]; // register image as read back.
	int m_phase [`EG_SLOTS];
	int m_level [`EG_SLOTS];
	bit m_key [`EG_SLOTS];
	int m_slot;
	int m_round;
	int m_cnt;
	int exp_level;
	int exp_slot;
	bit exp_tick;

	int errors;
	int cycle_cnt;
	logic [31:0] lfsr = 32'h51da_36c3;

	fm_eg_top dut_i
		(
		.mclk_i(mclk),
		.rst_n_i(rst_n),
		.psel_i(psel),
		.penable_i(penable),
		.pwrite_i(pwrite),
		.paddr_i(paddr),
		.pwdata_i(pwdata),
		.prdata_o(prdata),
		.pready_o(pready),
		.pslverr_o(pslverr),
		.eg_level_o(eg_level),
		.eg_slot_o(eg_slot)
		);

	initial
	begin
		forever #50 mclk = ~mclk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int field_mask(input int idx);
		case (idx)
			0, 1, 2: return 8'h1F;
			3: return 8'hFF;
			4, 5: return 8'h7F;
			6: return 8'h01;
			default: return 0; // unmapped index.
		endcase
	endfunction

	task automatic stop_with_failure;
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERR %0t: %s", $time, msg);
		stop_with_failure();
	endtask

	task automatic model_reset;
		for (int s = 0; s < `EG_SLOTS; s++)
		begin
			for (int i = 0; i < 8; i++)
				m_reg[s][i] = 0;
			m_phase[s] = PH_REL;
			m_level[s] = 10'h3FF;
			m_key[s] = 1'b0;
		end
		m_slot = 0;
		m_round = 0;
		m_cnt = 0;
		exp_level = 10'h3FF;
		exp_slot = 0;
		exp_tick = 1'b0;
	endtask

	// one clock of the model on the inputs the DUT saw at the last edge.
	task automatic model_step;
		int s;
		int key;
		int ph;
		int base;
		int r;
		int shift;
		int inc;
		int lvl;
		int dec;
		bit tick;
		bit rise;
		bit fall;
		bit step;
		s = m_slot;
		tick = (m_round == 0);
		key = m_reg[s][6];
		rise = (key != 0) && !m_key[s];
		fall = (key == 0) && m_key[s];
		ph = rise ? PH_ATT : (fall ? PH_REL : m_phase[s]);
		case (ph)
			PH_ATT: base = m_reg[s][0];
			PH_DEC: base = m_reg[s][1];
			PH_SUS: base = m_reg[s][2];
			default: base = (m_reg[s][3] % 16) * 2 + 1;
		endcase
		r = (base == 0) ? 0 : base * 2 + ((m_reg[s][5] % 32) >> (3 - m_reg[s][5] / 32));
		if (r > 63)
			r = 63;
		shift = (r < 48) ? 11 - r / 4 : 0;
		inc = (r < 48) ? 1 : 1 << (r / 4 - 11);
		step = (r != 0) && (m_cnt % (1 << shift) == 0);
		lvl = m_level[s];
		if (rise)
		begin
			if (r >= 62)
				lvl = 0; // instant attack.
		end
		else if (!fall && step)
		begin
			if (ph == PH_ATT)
			begin
				dec = (lvl / 16 + 1) * inc;
				lvl = (dec >= lvl) ? 0 : lvl - dec;
			end
			else
				lvl = (lvl + inc > 1023) ? 1023 : lvl + inc;
		end
		if (ph == PH_ATT && lvl == 0)
			ph = PH_DEC;
		else if (ph == PH_DEC && lvl >= (m_reg[s][3] / 16) * 32)
			ph = PH_SUS;
		if (tick)
		begin
			m_phase[s] = ph;
			m_level[s] = lvl;
			m_key[s] = (key != 0);
		end
		else
			lvl = m_level[s];
		exp_level = lvl + m_reg[s][4] * 8;
		if (exp_level > 1023)
			exp_level = 1023;
		exp_slot = s;
		exp_tick = tick;
		if (psel && penable && pwrite && paddr[2:0] != 3'd7)
			m_reg[paddr[4:3]][paddr[2:0]] = pwdata & field_mask(paddr[2:0]);
		m_slot = (m_slot + 1) % `EG_SLOTS;
		if (m_slot == 0)
		begin
			m_round = (m_round + 1) % `EG_ROUND_DIV;
			if (m_round == 0)
				m_cnt = (m_cnt + 1) % 4096;
		end
	endtask

	task automatic next_cycle;
		@(negedge mclk);
		if (rst_n)
			model_step();
		assert (eg_slot == exp_slot)
		else
			report_error($sformatf("eg_slot_o %0d expected %0d", eg_slot, exp_slot));
		assert (eg_level == exp_level)
		else
			report_error($sformatf("slot %0d eg_level_o %0h expected %0h",
				eg_slot, eg_level, exp_level));
	endtask

	task automatic apb_write(input int addr, input int data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr[4:0];
		pwdata = data[7:0];
		next_cycle();
		penable = 1'b1;
		next_cycle();
		assert (pready == 1'b1)
		else
			report_error("pready_o low in write access phase");
		assert (pslverr == (addr[2:0] == 3'd7))
		else
			report_error($sformatf("pslverr_o %0b on write to %0h", pslverr, addr));
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input int addr);
		int expected;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr[4:0];
		next_cycle();
		penable = 1'b1;
		next_cycle();
		expected = m_reg[addr[4:3]][addr[2:0]];
		assert (pready == 1'b1 && pslverr == (addr[2:0] == 3'd7))
		else
			report_error($sformatf("pready_o %0b pslverr_o %0b on read of %0h",
				pready, pslverr, addr));
		assert (prdata == expected)
		else
			report_error($sformatf("prdata_o %0h at %0h expected %0h",
				prdata, addr, expected));
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// output cycle of slot s that came from a tick round.
	task automatic wait_tick(input int s);
		int n;
		bit found;
		n = 0;
		found = 1'b0;
		while (!found && n < WAIT_LIMIT)
		begin
			next_cycle();
			n++;
			found = (eg_slot == s) && exp_tick;
		end
		if (!found)
		begin
			$display("timeout waiting for slot %0d in a tick round", s);
			stop_with_failure();
		end
	endtask

	task automatic wait_level(input int s, input int value);
		int n;
		bit found;
		n = 0;
		found = 1'b0;
		while (!found && n < WAIT_LIMIT)
		begin
			next_cycle();
			n++;
			found = (eg_slot == s) && (eg_level == value);
		end
		if (!found)
		begin
			$display("slot %0d never reached output level %0h", s, value);
			stop_with_failure();
		end
	endtask

	task automatic hold_level(input int s, input int value);
		repeat (HOLD_CYCLES)
		begin
			next_cycle();
			if (eg_slot == s)
				assert (eg_level == value)
				else
					report_error($sformatf("slot %0d left level %0h", s, value));
		end
	endtask

	task automatic rise_to_silence(input int s);
		int prev;
		int n;
		prev = 0;
		n = 0;
		while (!(eg_slot == s && eg_level == 10'h3FF) && n < WAIT_LIMIT)
		begin
			next_cycle();
			n++;
			if (eg_slot == s)
			begin
				assert (eg_level >= prev)
				else
					report_error($sformatf("slot %0d release fell to %0h", s, eg_level));
				prev = eg_level;
			end
		end
		if (!(eg_slot == s && eg_level == 10'h3FF))
		begin
			$display("slot %0d release never reached silence", s);
			stop_with_failure();
		end
	endtask

	task automatic regs_readback;
		for (int s = 0; s < `EG_SLOTS; s++)
			for (int i = 0; i < 7; i++)
				apb_write(s * 8 + i, rand_bits(8));
		for (int s = 0; s < `EG_SLOTS; s++)
			for (int i = 0; i < 8; i++)
				apb_read(s * 8 + i);
		apb_write(8 + 7, 8'hFF); // unmapped index leaves the registers alone.
		for (int i = 0; i < 8; i++)
			apb_read(8 + i);
	endtask

	task automatic slot_setup(input int s, input int sl_rr, input int tl);
		apb_write(s * 8 + 0, 31);
		apb_write(s * 8 + 1, 28);
		apb_write(s * 8 + 2, 0);
		apb_write(s * 8 + 3, sl_rr);
		apb_write(s * 8 + 4, tl);
		apb_write(s * 8 + 5, 0);
		apb_write(s * 8 + 6, 0);
		wait_tick(s); // stored key settles at 0.
		apb_write(s * 8 + 6, 1);
		wait_tick(s);
	endtask

	task automatic random_traffic;
		int addr;
		int idle;
		for (int t = 0; t < RAND_TXNS; t++)
		begin
			idle = rand_bits(3);
			repeat (idle) next_cycle();
			addr = rand_bits(5);
			if (rand_bits(2) == 0)
				addr = (addr & 24) | 6; // favour key toggles.
			if (rand_bits(1))
				apb_write(addr, rand_bits(8));
			else
				apb_read(addr);
		end
	endtask

	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT)
		begin
			@(posedge mclk);
			cycle_cnt++;
		end
		$display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
		stop_with_failure();
	end

	initial
	begin
		errors = 0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		model_reset();
		repeat (16) next_cycle();
		rst_n = 1'b1;

		for (int i = 0; i < 8; i++)
		begin
			next_cycle();
			assert (eg_slot == i % 4 && eg_level == 10'h3FF)
			else
				report_error($sformatf("boot output slot %0d level %0h", eg_slot, eg_level));
		end

		regs_readback();

		// slot 1 with sl 2, rr 15, tl 4.
		slot_setup(1, 8'h2F, 4);
		assert (eg_level == 32)
		else
			report_error($sformatf("instant attack gave %0h", eg_level));
		wait_level(1, 96);
		hold_level(1, 96);

		apb_write(8 + 6, 0);
		rise_to_silence(1);
		hold_level(1, 10'h3FF);

		// slot 2 with tl 127 saturates.
		slot_setup(2, 8'hF0, 127);
		assert (eg_level == 1016)
		else
			report_error($sformatf("tl offset gave %0h", eg_level));
		wait_level(2, 10'h3FF);
		hold_level(2, 10'h3FF);

		random_traffic();

		if (errors == 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
			stop_with_failure();
	end

endmodule
